/* include/bus_consts.svh */
`ifndef BUS_CONSTS_SVH
`define BUS_CONSTS_SVH

// Region bounds with map low
`define RAM_LO       32'h0000_0000
`define RAM_HI       32'h0000_3fff
`define SSRAM_LO     32'h0000_4000
`define SSRAM_HI     32'h007f_ffff
`define LED_LO       32'h0080_0000
`define LED_HI       32'h0080_07ff
`define IO_LO        32'h0080_0800
`define IO_HI        32'h0080_0fff
`define FLASH_LO     32'h0800_0000
`define FLASH_HI     32'h0fff_ffff
`define SDRAM_LO     32'h1000_0000
`define SDRAM_HI     32'h17ff_ffff
`define ROM_LO       32'hffff_0000
`define ROM_HI       32'hffff_ffbf
`define VEC_LO       32'hffff_ffc0
`define VEC_HI       32'hffff_ffff

// Map high moves RAM up and lets SSRAM start at zero
`define SSRAM_MAP_LO 32'h0000_0000
`define RAM_MAP_LO   32'hffff_8000
`define RAM_MAP_HI   32'hffff_bfff

// Chip-select codes
`define CS_NONE      4'd0
`define CS_VEC       4'd1
`define CS_ROM       4'd2
`define CS_RAM       4'd3
`define CS_IO        4'd4
`define CS_LED       4'd5
`define CS_SSRAM     4'd6
`define CS_SDRAM     4'd7
`define CS_FLASH     4'd8

`define RAM_DEPTH    4096
`define ROM_DEPTH    16384
`define VEC_COUNT    16
`define IO_WORDS     512
`define IO_ID        32'h1b0c_0001

`endif

/* verilog/bus_pkg.sv */
package bus_pkg;

  typedef logic [31:0] addr_t; // Byte address
  typedef logic [31:0] data_t;
  typedef logic [3:0]  cs_t;   // Zero when nothing is mapped

  typedef enum logic [1:0] {
    cyc_idle  = 2'b00,
    cyc_start = 2'b01, // Address latch
    cyc_pre   = 2'b10, // Write lands, read data valid
    cyc_post  = 2'b11  // Data visible to the master
  } cycle_state_t;

  // Request as driven by the processor
  typedef struct packed {
    logic  read;
    logic  write;
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  // Broadcast from the sequencer to every slave
  typedef struct packed {
    logic start;
    logic commit;
    cs_t  cs;
  } bus_ctl_t;

endpackage

/* verilog/mmu.sv */
`timescale 1ns/1ps
`include "bus_consts.svh"

module mmu (
  input  logic             clock,
  input  logic             reset_n,
  input  bus_pkg::bus_req_t req,
  input  logic             map,
  output bus_pkg::bus_ctl_t ctl,
  output logic             buswait,
  output bus_pkg::cs_t     chipselect
);

  bus_pkg::cycle_state_t state_q;
  bus_pkg::cycle_state_t state_d;
  bus_pkg::cs_t          cs;
  logic                  req_active;

  function automatic logic in_range(input bus_pkg::addr_t a, input bus_pkg::addr_t lo,
                                    input bus_pkg::addr_t hi);
    return (a >= lo) && (a <= hi);
  endfunction

  // First matching region wins, so RAM at ffff8000 shadows ROM when map is set
  function automatic bus_pkg::cs_t decode(input bus_pkg::addr_t a, input logic m);
    bus_pkg::cs_t c;
    if (!m && in_range(a, `RAM_LO, `RAM_HI)) begin
      c = `CS_RAM;
    end else if (in_range(a, m ? `SSRAM_MAP_LO : `SSRAM_LO, `SSRAM_HI)) begin
      c = `CS_SSRAM;
    end else if (in_range(a, `LED_LO, `LED_HI)) begin
      c = `CS_LED;
    end else if (in_range(a, `IO_LO, `IO_HI)) begin
      c = `CS_IO;
    end else if (in_range(a, `FLASH_LO, `FLASH_HI)) begin
      c = `CS_FLASH;
    end else if (in_range(a, `SDRAM_LO, `SDRAM_HI)) begin
      c = `CS_SDRAM;
    end else if (m && in_range(a, `RAM_MAP_LO, `RAM_MAP_HI)) begin
      c = `CS_RAM;
    end else if (in_range(a, `ROM_LO, `ROM_HI)) begin
      c = `CS_ROM;
    end else if (in_range(a, `VEC_LO, `VEC_HI)) begin
      c = `CS_VEC;
    end else begin
      c = `CS_NONE;
    end
    return c;
  endfunction

  assign req_active = req.read | req.write;
  assign cs         = decode(req.addr, map);

  assign chipselect = req_active ? cs : `CS_NONE;
  assign buswait    = (state_q != bus_pkg::cyc_post);

  assign ctl.start  = (state_q == bus_pkg::cyc_start);
  assign ctl.commit = (state_q == bus_pkg::cyc_pre);
  assign ctl.cs     = cs;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= bus_pkg::cyc_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      bus_pkg::cyc_idle: begin
        if (req_active) begin
          state_d = bus_pkg::cyc_start;
        end
      end
      bus_pkg::cyc_start: begin
        // Request withdrawn before commit means no access at all
        state_d = req_active ? bus_pkg::cyc_pre : bus_pkg::cyc_idle;
      end
      bus_pkg::cyc_pre: begin
        state_d = bus_pkg::cyc_post;
      end
      bus_pkg::cyc_post: begin
        if (!req_active) begin // Master has taken the data
          state_d = bus_pkg::cyc_idle;
        end
      end
      default: begin
        state_d = bus_pkg::cyc_idle;
      end
    endcase
  end

endmodule

/* verilog/int_ram.sv */
`timescale 1ns/1ps
`include "bus_consts.svh"

module int_ram (
  input  logic             clock,
  input  bus_pkg::bus_req_t req,
  input  bus_pkg::bus_ctl_t ctl,
  output bus_pkg::data_t   rdata
);

  localparam int ram_aw = $clog2(`RAM_DEPTH);

  bus_pkg::data_t    mem [`RAM_DEPTH];
  logic [ram_aw-1:0] idx_q; // Word index from address bits 13:2
  logic              sel;

  assign sel = (ctl.cs == `CS_RAM);

  always_ff @(posedge clock) begin
    if (ctl.start && sel) begin
      idx_q <= req.addr[ram_aw+1:2];
    end
  end

  always_ff @(posedge clock) begin
    if (ctl.commit && sel && req.write) begin
      mem[idx_q] <= req.wdata;
    end
  end

  assign rdata = mem[idx_q]; // Registered address, so valid one cycle after start

endmodule

/* verilog/int_rom.sv */
`timescale 1ns/1ps
`include "bus_consts.svh"

module int_rom (
  input  logic             clock,
  input  bus_pkg::bus_req_t req,
  input  bus_pkg::bus_ctl_t ctl,
  output bus_pkg::data_t   rdata
);

  localparam int rom_aw = $clog2(`ROM_DEPTH);

  bus_pkg::data_t    mem [`ROM_DEPTH];
  logic [rom_aw-1:0] idx_q;

  // Words the hex file does not cover stay zero
  initial begin
    for (int i = 0; i < `ROM_DEPTH; i++) begin
      mem[i] = '0;
    end
    $readmemh("rom.hex", mem);
  end

  always_ff @(posedge clock) begin
    if (ctl.start && (ctl.cs == `CS_ROM)) begin
      idx_q <= req.addr[rom_aw+1:2]; // Bits 15:2
    end
  end

  assign rdata = mem[idx_q]; // No write port

endmodule

/* verilog/vector_table.sv */
`timescale 1ns/1ps
`include "bus_consts.svh"

module vector_table (
  input  logic             clock,
  input  logic             reset_n,
  input  bus_pkg::bus_req_t req,
  input  bus_pkg::bus_ctl_t ctl,
  output bus_pkg::data_t   rdata
);

  localparam int vec_aw = $clog2(`VEC_COUNT);

  bus_pkg::data_t    vec_q [`VEC_COUNT];
  logic [vec_aw-1:0] idx_q; // Address bits 5:2
  logic              sel;

  assign sel = (ctl.cs == `CS_VEC);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      idx_q <= '0;
    end else if (ctl.start && sel) begin
      idx_q <= req.addr[vec_aw+1:2];
    end
  end

  // Vectors come up cleared so a stray interrupt jumps to zero
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      vec_q <= '{default: '0};
    end else if (ctl.commit && sel && req.write) begin
      vec_q[idx_q] <= req.wdata;
    end
  end

  assign rdata = vec_q[idx_q];

endmodule

/* verilog/io_regs.sv */
`timescale 1ns/1ps
`include "bus_consts.svh"

module io_regs (
  input  logic             clock,
  input  logic             reset_n,
  input  bus_pkg::bus_req_t req,
  input  bus_pkg::bus_ctl_t ctl,
  output bus_pkg::data_t   rdata,
  output bus_pkg::data_t   led
);

  localparam int io_aw = $clog2(`IO_WORDS);
  localparam logic [io_aw-1:0] scratch_idx = io_aw'(0);
  localparam logic [io_aw-1:0] led_idx     = io_aw'(1);
  localparam logic [io_aw-1:0] id_idx      = io_aw'(2);

  logic [io_aw-1:0] idx_q;
  bus_pkg::data_t   scratch_q;
  bus_pkg::data_t   led_q;
  logic             sel;

  assign sel = (ctl.cs == `CS_IO);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      idx_q     <= '0;
      scratch_q <= '0;
      led_q     <= '0;
    end else begin
      if (ctl.start && sel) begin
        idx_q <= req.addr[io_aw+1:2];
      end
      if (ctl.commit && sel && req.write) begin
        if (idx_q == scratch_idx) scratch_q <= req.wdata;
        if (idx_q == led_idx)     led_q     <= req.wdata; // ID word ignores writes
      end
    end
  end

  always_comb begin
    case (idx_q)
      scratch_idx: rdata = scratch_q;
      led_idx:     rdata = led_q;
      id_idx:      rdata = `IO_ID;
      default:     rdata = '0; // Rest of the window is empty
    endcase
  end

  assign led = led_q;

endmodule

/* verilog/data_select.sv */
`timescale 1ns/1ps
`include "bus_consts.svh"

module data_select (
  input  logic             clock,
  input  logic             reset_n,
  input  bus_pkg::bus_ctl_t ctl,
  input  bus_pkg::data_t   ram_rdata,
  input  bus_pkg::data_t   rom_rdata,
  input  bus_pkg::data_t   vec_rdata,
  input  bus_pkg::data_t   io_rdata,
  input  bus_pkg::data_t   ext_rdata,
  output bus_pkg::data_t   rdata
);

  bus_pkg::data_t sel_data;
  bus_pkg::data_t rdata_q;

  always_comb begin
    case (ctl.cs)
      `CS_VEC: sel_data = vec_rdata;
      `CS_ROM: sel_data = rom_rdata;
      `CS_RAM: sel_data = ram_rdata;
      `CS_IO:  sel_data = io_rdata;
      `CS_LED, `CS_SSRAM, `CS_SDRAM, `CS_FLASH: sel_data = ext_rdata; // Off-chip
      default: sel_data = '0; // Unmapped
    endcase
  end

  // Held until the next access commits
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      rdata_q <= '0;
    end else if (ctl.commit) begin
      rdata_q <= sel_data;
    end
  end

  assign rdata = rdata_q;

endmodule

/* verilog/bus_subsystem.sv */
`timescale 1ns/1ps

module bus_subsystem (
  input  logic             clock,
  input  logic             reset_n,
  input  bus_pkg::bus_req_t req,
  input  logic             map,
  input  bus_pkg::data_t   ext_rdata,
  output bus_pkg::data_t   rdata,
  output logic             buswait,
  output bus_pkg::cs_t     chipselect,
  output bus_pkg::data_t   led
);

  bus_pkg::bus_ctl_t ctl;
  bus_pkg::data_t    ram_rdata;
  bus_pkg::data_t    rom_rdata;
  bus_pkg::data_t    vec_rdata;
  bus_pkg::data_t    io_rdata;

  mmu i_mmu (
    .clock      (clock),
    .reset_n    (reset_n),
    .req        (req),
    .map        (map),
    .ctl        (ctl),
    .buswait    (buswait),
    .chipselect (chipselect)
  );

  int_ram i_int_ram (
    .clock (clock),
    .req   (req),
    .ctl   (ctl),
    .rdata (ram_rdata)
  );

  int_rom i_int_rom (
    .clock (clock),
    .req   (req),
    .ctl   (ctl),
    .rdata (rom_rdata)
  );

  vector_table i_vector_table (
    .clock   (clock),
    .reset_n (reset_n),
    .req     (req),
    .ctl     (ctl),
    .rdata   (vec_rdata)
  );

  io_regs i_io_regs (
    .clock   (clock),
    .reset_n (reset_n),
    .req     (req),
    .ctl     (ctl),
    .rdata   (io_rdata),
    .led     (led)
  );

  data_select i_data_select (
    .clock     (clock),
    .reset_n   (reset_n),
    .ctl       (ctl),
    .ram_rdata (ram_rdata),
    .rom_rdata (rom_rdata),
    .vec_rdata (vec_rdata),
    .io_rdata  (io_rdata),
    .ext_rdata (ext_rdata),
    .rdata     (rdata)
  );

endmodule

/* verif/bus_subsystem_tb.sv */
`timescale 1ns/1ps
`include "bus_consts.svh"

module bus_subsystem_tb;

  localparam logic [2:0] k_wr    = 3'd0; // Write with only the select checked
  localparam logic [2:0] k_fix   = 3'd1; // Read with the word given in the table
  localparam logic [2:0] k_ext   = 3'd2; // Read of an off-chip region
  localparam logic [2:0] k_mdl   = 3'd3; // Read checked against the model
  localparam logic [2:0] k_abort = 3'd4; // Write withdrawn during start

  typedef struct packed {
    logic [2:0]     kind;
    logic           map;
    bus_pkg::addr_t addr;
    bus_pkg::data_t wdata;
    bus_pkg::data_t exp;
    bus_pkg::cs_t   cs;
  } entry_t;

  logic              clock;
  logic              reset_n;
  bus_pkg::bus_req_t req;
  logic              map;
  bus_pkg::data_t    ext_rdata;
  bus_pkg::data_t    rdata;
  logic              buswait;
  bus_pkg::cs_t      chipselect;
  bus_pkg::data_t    led;

  entry_t            entries [$];
  string             names [$];
  logic              table_ready;
  logic [31:0]       lfsr_q;

  // Expected contents of the writable slaves
  bus_pkg::data_t    ram_model [`RAM_DEPTH];
  bus_pkg::data_t    vec_model [`VEC_COUNT];
  bus_pkg::data_t    io_scratch;
  bus_pkg::data_t    io_led;

  bus_subsystem i_bus_subsystem (
    .clock      (clock),
    .reset_n    (reset_n),
    .req        (req),
    .map        (map),
    .ext_rdata  (ext_rdata),
    .rdata      (rdata),
    .buswait    (buswait),
    .chipselect (chipselect),
    .led        (led)
  );

  always #4 clock = ~clock;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic draw_word(output bus_pkg::data_t w);
    for (int b = 0; b < 32; b++) begin
      lfsr_q = lfsr_step(lfsr_q);
      w[b]   = lfsr_q[0];
    end
  endtask

  task automatic check_value(input string test, input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      $display("ERR %s %s expected %h actual %h", test, what, exp, act);
      $display("Done: errors found");
      $fatal(1);
    end
  endtask

  task automatic add_entry(input string name, input logic [2:0] kind, input logic m,
                           input bus_pkg::addr_t a, input bus_pkg::data_t wd,
                           input bus_pkg::data_t exp, input bus_pkg::cs_t cs);
    entry_t e;
    e.kind  = kind;
    e.map   = m;
    e.addr  = a;
    e.wdata = wd;
    e.exp   = exp;
    e.cs    = cs;
    entries.push_back(e);
    names.push_back(name);
  endtask

  function automatic bus_pkg::data_t expected_word(input entry_t e);
    logic [31:0]    word;
    bus_pkg::data_t v;
    word = (e.addr - `IO_LO) >> 2; // Offset into the IO window
    v    = '0;
    case (e.cs)
      `CS_RAM: v = ram_model[e.addr[13:2]];
      `CS_VEC: v = vec_model[e.addr[5:2]];
      `CS_IO: begin
        if (word == 32'd0) v = io_scratch;
        if (word == 32'd1) v = io_led;
        if (word == 32'd2) v = `IO_ID;
      end
      default: v = '0;
    endcase
    return v;
  endfunction

  task automatic track_write(input entry_t e);
    logic [31:0] word;
    word = (e.addr - `IO_LO) >> 2;
    case (e.cs)
      `CS_RAM: ram_model[e.addr[13:2]] = e.wdata;
      `CS_VEC: vec_model[e.addr[5:2]] = e.wdata;
      `CS_IO: begin
        if (word == 32'd0) io_scratch = e.wdata;
        if (word == 32'd1) io_led = e.wdata; // ID word stays fixed
      end
      default: ; // ROM and off-chip words are not tracked
    endcase
  endtask

  task automatic build_table;
    add_entry("ram_lo_wr",   k_wr,  1'b0, 32'h0000_0000, 32'h1111_1111, 32'h0, `CS_RAM);
    add_entry("ram_lo_rd",   k_mdl, 1'b0, 32'h0000_0000, 32'h0, 32'h0, `CS_RAM);
    add_entry("ram_hi_wr",   k_wr,  1'b0, 32'h0000_3ffc, 32'h2222_2222, 32'h0, `CS_RAM);
    add_entry("ram_hi_rd",   k_mdl, 1'b0, 32'h0000_3ffc, 32'h0, 32'h0, `CS_RAM);
    add_entry("ssram_lo",    k_ext, 1'b0, 32'h0000_4000, 32'h0, 32'h0, `CS_SSRAM);
    add_entry("ssram_hi",    k_ext, 1'b0, 32'h007f_fffc, 32'h0, 32'h0, `CS_SSRAM);
    add_entry("led_lo",      k_ext, 1'b0, 32'h0080_0000, 32'h0, 32'h0, `CS_LED);
    add_entry("led_hi",      k_ext, 1'b0, 32'h0080_07fc, 32'h0, 32'h0, `CS_LED);
    add_entry("io_lo",       k_mdl, 1'b0, 32'h0080_0800, 32'h0, 32'h0, `CS_IO);
    add_entry("io_hi",       k_mdl, 1'b0, 32'h0080_0ffc, 32'h0, 32'h0, `CS_IO);
    add_entry("gap_io",      k_fix, 1'b0, 32'h0080_1000, 32'h0, 32'h0, `CS_NONE);
    add_entry("gap_flash",   k_fix, 1'b0, 32'h07ff_fffc, 32'h0, 32'h0, `CS_NONE);
    add_entry("flash_lo",    k_ext, 1'b0, 32'h0800_0000, 32'h0, 32'h0, `CS_FLASH);
    add_entry("flash_hi",    k_ext, 1'b0, 32'h0fff_fffc, 32'h0, 32'h0, `CS_FLASH);
    add_entry("sdram_lo",    k_ext, 1'b0, 32'h1000_0000, 32'h0, 32'h0, `CS_SDRAM);
    add_entry("sdram_hi",    k_ext, 1'b0, 32'h17ff_fffc, 32'h0, 32'h0, `CS_SDRAM);
    add_entry("gap_sdram",   k_fix, 1'b0, 32'h1800_0000, 32'h0, 32'h0, `CS_NONE);
    add_entry("gap_rom",     k_fix, 1'b0, 32'hfffe_fffc, 32'h0, 32'h0, `CS_NONE);
    add_entry("rom_lo",      k_fix, 1'b0, 32'hffff_0000, 32'h0, 32'hc0de_0000, `CS_ROM);
    add_entry("rom_8000",    k_fix, 1'b0, 32'hffff_8000, 32'h0, 32'h0, `CS_ROM);
    add_entry("rom_hi",      k_fix, 1'b0, 32'hffff_ffbc, 32'h0, 32'h0, `CS_ROM);
    add_entry("vec_lo",      k_mdl, 1'b0, 32'hffff_ffc0, 32'h0, 32'h0, `CS_VEC);
    add_entry("vec_hi",      k_mdl, 1'b0, 32'hffff_fffc, 32'h0, 32'h0, `CS_VEC);
    // Map set moves RAM up and SSRAM down to zero
    add_entry("m_ssram_0",   k_ext, 1'b1, 32'h0000_0000, 32'h0, 32'h0, `CS_SSRAM);
    add_entry("m_rom_below", k_fix, 1'b1, 32'hffff_7ffc, 32'h0, 32'h0, `CS_ROM);
    add_entry("m_ram_lo",    k_mdl, 1'b1, 32'hffff_8000, 32'h0, 32'h0, `CS_RAM);
    add_entry("m_ram_hi",    k_mdl, 1'b1, 32'hffff_bffc, 32'h0, 32'h0, `CS_RAM);
    add_entry("m_rom_above", k_fix, 1'b1, 32'hffff_c000, 32'h0, 32'h0, `CS_ROM);
    add_entry("m_ram_wr",    k_wr,  1'b1, 32'hffff_8010, 32'h4444_4444, 32'h0, `CS_RAM);
    add_entry("ram_10_rd",   k_mdl, 1'b0, 32'h0000_0010, 32'h0, 32'h0, `CS_RAM);
    add_entry("ram_20_wr",   k_wr,  1'b0, 32'h0000_0020, 32'h5555_5555, 32'h0, `CS_RAM);
    add_entry("abort_wr",    k_abort, 1'b0, 32'h0000_0020, 32'hdead_beef, 32'h0, `CS_RAM);
    add_entry("ram_20_rd",   k_mdl, 1'b0, 32'h0000_0020, 32'h0, 32'h0, `CS_RAM);
    add_entry("rom_w5",      k_fix, 1'b0, 32'hffff_0014, 32'h0, 32'hc0de_0005, `CS_ROM);
    add_entry("rom_w15",     k_fix, 1'b0, 32'hffff_003c, 32'h0, 32'hc0de_000f, `CS_ROM);
    add_entry("rom_w16",     k_fix, 1'b0, 32'hffff_0040, 32'h0, 32'h0, `CS_ROM);
    add_entry("rom_wr5",     k_wr,  1'b0, 32'hffff_0014, 32'hffff_ffff, 32'h0, `CS_ROM);
    add_entry("rom_rd5",     k_fix, 1'b0, 32'hffff_0014, 32'h0, 32'hc0de_0005, `CS_ROM);
    add_entry("vec3_wr",     k_wr,  1'b0, 32'hffff_ffcc, 32'h0000_1234, 32'h0, `CS_VEC);
    add_entry("vec3_rd",     k_mdl, 1'b0, 32'hffff_ffcc, 32'h0, 32'h0, `CS_VEC);
    add_entry("vec4_rd",     k_mdl, 1'b0, 32'hffff_ffd0, 32'h0, 32'h0, `CS_VEC);
    add_entry("scratch_wr",  k_wr,  1'b0, 32'h0080_0800, 32'ha5a5_5a5a, 32'h0, `CS_IO);
    add_entry("scratch_rd",  k_mdl, 1'b0, 32'h0080_0800, 32'h0, 32'h0, `CS_IO);
    add_entry("led_wr",      k_wr,  1'b0, 32'h0080_0804, 32'h0000_00ff, 32'h0, `CS_IO);
    add_entry("led_rd",      k_mdl, 1'b0, 32'h0080_0804, 32'h0, 32'h0, `CS_IO);
    add_entry("id_wr",       k_wr,  1'b0, 32'h0080_0808, 32'hffff_ffff, 32'h0, `CS_IO);
    add_entry("id_rd",       k_mdl, 1'b0, 32'h0080_0808, 32'h0, 32'h0, `CS_IO);
    add_entry("io_w3_rd",    k_mdl, 1'b0, 32'h0080_080c, 32'h0, 32'h0, `CS_IO);
  endtask

  // Starts and ends 1 ns past a rising edge
  task automatic run_access(input int i);
    entry_t e;
    string  n;
    int     edges;
    e     = entries[i];
    n     = names[i];
    edges = 0;
    draw_word(ext_rdata);
    map       = e.map;
    req.addr  = e.addr;
    req.wdata = e.wdata;
    req.write = (e.kind == k_wr) || (e.kind == k_abort);
    req.read  = !req.write;
    if (e.kind == k_abort) begin
      @(posedge clock);
      #1;
      check_value(n, "buswait in start", 32'd1, 32'(buswait));
      req = '0; // Withdrawn before commit
      repeat (2) @(posedge clock); // A cycle that went on would be in post by now
      #1;
      check_value(n, "buswait after drop", 32'd1, 32'(buswait));
    end else begin
      do begin
        @(posedge clock);
        #1;
        edges++;
      end while (buswait && edges < 8);
      check_value(n, "edges to ready", 32'd3, 32'(edges));
      check_value(n, "chipselect", 32'(e.cs), 32'(chipselect));
      if (e.kind == k_fix) check_value(n, "rdata", e.exp, rdata);
      if (e.kind == k_ext) check_value(n, "rdata", ext_rdata, rdata);
      if (e.kind == k_mdl) check_value(n, "rdata", expected_word(e), rdata);
      @(posedge clock);
      #1;
      check_value(n, "buswait held", 32'd0, 32'(buswait));
      req = '0;
      #1;
      check_value(n, "chipselect idle", 32'd0, 32'(chipselect));
      @(posedge clock);
      #1;
      check_value(n, "buswait idle", 32'd1, 32'(buswait));
      if (e.kind == k_wr) track_write(e);
    end
    check_value(n, "led", io_led, led);
  endtask

  initial begin
    clock       = 1'b0;
    reset_n     = 1'b0;
    req         = '0;
    map         = 1'b0;
    ext_rdata   = '0;
    table_ready = 1'b0;
    lfsr_q      = 32'hc527;
    io_scratch  = '0;
    io_led      = '0;
    for (int v = 0; v < `VEC_COUNT; v++) begin
      vec_model[v] = '0; // Vectors clear on reset
    end
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clock);
    #1;
    reset_n = 1'b1;
    check_value("reset", "buswait", 32'd1, 32'(buswait));
    check_value("reset", "chipselect", 32'd0, 32'(chipselect));
    check_value("reset", "rdata", 32'd0, rdata);
    check_value("reset", "led", 32'd0, led);
    for (int i = 0; i < entries.size(); i++) begin
      run_access(i);
    end
    $display("Done: no errors");
    $finish;
  end

  initial begin
    wait (table_ready);
    repeat (entries.size() * 10) @(posedge clock);
    $display("Watchdog expired before all table entries were applied");
    $display("Done: errors found");
    $fatal(1);
  end

endmodule

/* rom.hex */
c0de0000
c0de0001
c0de0002
c0de0003
c0de0004
c0de0005
c0de0006
c0de0007
c0de0008
c0de0009
c0de000a
c0de000b
c0de000c
c0de000d
c0de000e
c0de000f

/* src.f */
+incdir+include
verilog/bus_pkg.sv
verilog/mmu.sv
verilog/int_ram.sv
verilog/int_rom.sv
verilog/vector_table.sv
verilog/io_regs.sv
verilog/data_select.sv
verilog/bus_subsystem.sv
verif/bus_subsystem_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f src.f \
  --top-module bus_subsystem_tb --Mdir obj_dir -o sim

out=$(./obj_dir/sim 2>&1) || true
printf '%s\n' "$out"

if grep -qF "Done: no errors" <<< "$out"; then
  exit 0
fi
exit 1
